// File: common/uart_dbg_pkg.sv
// UART debug loader shared definitions
// Protocol byte codes, field sizes and the command controller state encoding

package uart_dbg_pkg;

  ////////////////////////////////////////
  // Field sizes
  ////////////////////////////////////////

  localparam int DATA_W      = 8;
  localparam int ADDR_W      = 64;
  localparam int EXIT_W      = 32;
  localparam int FIELD_BYTES = 8;
  localparam int EXIT_BYTES  = 4;

  typedef logic [DATA_W-1:0] byte_t;

  ////////////////////////////////////////
  // Protocol codes
  ////////////////////////////////////////

  // Host commands, the first byte of a request
  typedef enum logic [7:0] {
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } cmd_e;

  // Reply and challenge codes
  localparam byte_t CODE_ACK = 8'h06;
  localparam byte_t CODE_EOT = 8'h04;
  localparam byte_t CODE_EOC = 8'h14;

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    IDLE,
    GET_ADDR,
    GET_LEN,
    SEND_ACK,
    WR_DATA,
    RD_FETCH,
    RD_SEND,
    SEND_EOT,
    EXEC_ACK,
    EOC_CODE,
    EOC_EXIT
  } ctrl_state_e;

endpackage

// File: uart/uart_rx.sv
// UART receiver
// Samples each bit at mid-bit, checks even parity and strobes good bytes

`timescale 1ns/1ps

module uart_rx import uart_dbg_pkg::*; #(
  parameter int CLKS_PER_BIT = 16,
  parameter int PARITY_EN    = 1
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_data_o
);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic             par_err_q;
  byte_t            shift_q;
  logic             mid_bit;

  // Line after the two synchronizer flops is sync_q[1]
  assign mid_bit   = (clk_cnt_q == BIT_LAST);
  assign rx_data_o = shift_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= RX_IDLE;
      sync_q     <= 2'b11;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      par_err_q  <= 1'b0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          par_err_q <= 1'b0;
          if (!sync_q[1]) state_q <= RX_START;
        end
        RX_START: begin
          // Confirm start bit at its middle, else treat as a glitch
          if (clk_cnt_q == HALF_LAST) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= sync_q[1] ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            clk_cnt_q <= '0;
            shift_q   <= {sync_q[1], shift_q[DATA_W-1:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'(DATA_W - 1)) begin
              state_q <= (PARITY_EN != 0) ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (mid_bit) begin
            clk_cnt_q <= '0;
            par_err_q <= sync_q[1] ^ (^shift_q);
            state_q   <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (mid_bit) begin
            rx_valid_o <= sync_q[1] & ~par_err_q;
            state_q    <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Two bytes are at least a frame apart
  assert property (@(posedge clk) disable iff (rst_i) rx_valid_o |=> !rx_valid_o)
    else $error("rx_valid_o high for two cycles");

endmodule

// File: uart/uart_tx.sv
// UART transmitter
// Frames a byte with start, optional even parity and stop bits

`timescale 1ns/1ps

module uart_tx import uart_dbg_pkg::*; #(
  parameter int CLKS_PER_BIT = 16,
  parameter int PARITY_EN    = 1
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  tx_start_i,
  input  byte_t tx_data_i,
  output logic  tx_busy_o,
  output logic  tx_o
);

  localparam int FRAME_BITS = DATA_W + 2 + ((PARITY_EN != 0) ? 1 : 0);
  // Bits left after the start bit
  localparam int SHIFT_W    = FRAME_BITS - 1;
  localparam int CNT_W      = $clog2(CLKS_PER_BIT);
  localparam int BIT_W      = $clog2(FRAME_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  logic [SHIFT_W-1:0] shift_q;
  logic [SHIFT_W-1:0] frame;
  logic [CNT_W-1:0]   clk_cnt_q;
  logic [BIT_W-1:0]   bit_cnt_q;

  // Stop, parity and data, sent LSB first
  assign frame = (PARITY_EN != 0) ? SHIFT_W'({1'b1, ^tx_data_i, tx_data_i})
                                  : SHIFT_W'({1'b1, tx_data_i});

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!tx_busy_o) begin
      if (tx_start_i) begin
        tx_o      <= 1'b0;
        tx_busy_o <= 1'b1;
        shift_q   <= frame;
        clk_cnt_q <= '0;
        bit_cnt_q <= BIT_W'(SHIFT_W);
      end
    end else if (clk_cnt_q == BIT_LAST) begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == '0) begin
        // Stop bit done, line already high
        tx_busy_o <= 1'b0;
      end else begin
        tx_o      <= shift_q[0];
        shift_q   <= shift_q >> 1;
        bit_cnt_q <= bit_cnt_q - 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // Controller must wait for the frame to finish
  assert property (@(posedge clk) disable iff (rst_i) tx_start_i |-> !tx_busy_o)
    else $error("tx_start_i while transmitter busy");

endmodule

// File: logic/dbg_byte_mem.sv
// Loader byte memory
// Single port, synchronous write and registered read

`timescale 1ns/1ps

module dbg_byte_mem import uart_dbg_pkg::*; #(
  parameter int MEM_AW = 10
) (
  input  logic              clk,
  input  logic              we_i,
  input  logic [MEM_AW-1:0] addr_i,
  input  byte_t             wdata_i,
  output byte_t             rdata_o
);

  localparam int DEPTH = 2 ** MEM_AW;

  byte_t mem_q [DEPTH];

  // Read returns the old byte on a same-cycle write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

// File: logic/dbg_cmd_ctrl.sv
// Debug command controller
// Parses host frames, moves bytes to and from memory and sequences replies

`timescale 1ns/1ps

module dbg_cmd_ctrl import uart_dbg_pkg::*; #(
  parameter int MEM_AW = 10
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               rx_valid_i,
  input  byte_t              rx_data_i,
  input  logic               tx_busy_i,
  output logic               tx_start_o,
  output byte_t              tx_data_o,
  output logic               mem_we_o,
  output logic [MEM_AW-1:0]  mem_addr_o,
  output byte_t              mem_wdata_o,
  input  byte_t              mem_rdata_i,
  input  logic               eoc_i,
  input  logic [EXIT_W-1:0]  exit_code_i,
  output logic               exec_o,
  output logic [ADDR_W-1:0]  exec_addr_o
);

  localparam int CNT_W = $clog2(FIELD_BYTES);

  ctrl_state_e            state_q;
  cmd_e                   cmd_q;
  logic                   ack_only_q;
  logic [CNT_W-1:0]       byte_cnt_q;
  logic [ADDR_W-1:DATA_W] field_q;
  logic [ADDR_W-1:0]      field_next;
  logic [ADDR_W-1:0]      addr_q;
  logic [ADDR_W-1:0]      len_q;
  logic [EXIT_W-1:0]      exit_q;
  logic                   send_state;
  logic                   field_done;
  logic                   last_byte;

  ////////////////////////////////////////
  // Datapath outputs
  ////////////////////////////////////////

  // Fields arrive least significant byte first
  assign field_next = {rx_data_i, field_q[ADDR_W-1:DATA_W]};
  assign field_done = rx_valid_i && (byte_cnt_q == CNT_W'(FIELD_BYTES - 1));
  assign last_byte  = (len_q == 64'd1);

  assign send_state = state_q inside {SEND_ACK, RD_SEND, SEND_EOT,
                                      EXEC_ACK, EOC_CODE, EOC_EXIT};
  assign tx_start_o = send_state && !tx_busy_i;
  assign exec_o     = (state_q == EXEC_ACK) && !tx_busy_i;

  assign mem_we_o    = (state_q == WR_DATA) && rx_valid_i;
  assign mem_addr_o  = addr_q[MEM_AW-1:0];
  assign mem_wdata_o = rx_data_i;

  always_comb begin
    case (state_q)
      SEND_ACK, EXEC_ACK: tx_data_o = CODE_ACK;
      RD_SEND:            tx_data_o = mem_rdata_i;
      SEND_EOT:           tx_data_o = CODE_EOT;
      EOC_CODE:           tx_data_o = CODE_EOC;
      EOC_EXIT:           tx_data_o = exit_q[DATA_W-1:0];
      default:            tx_data_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= IDLE;
      cmd_q       <= CMD_READ;
      ack_only_q  <= 1'b0;
      byte_cnt_q  <= '0;
      exec_addr_o <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          byte_cnt_q <= '0;
          if (eoc_i) begin
            exit_q  <= exit_code_i;
            state_q <= EOC_CODE;
          end else if (rx_valid_i) begin
            case (rx_data_i)
              CODE_ACK: begin
                ack_only_q <= 1'b1;
                state_q    <= SEND_ACK;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= cmd_e'(rx_data_i);
                state_q <= GET_ADDR;
              end
              default: state_q <= IDLE;
            endcase
          end
        end
        GET_ADDR, GET_LEN: begin
          if (rx_valid_i) begin
            field_q    <= field_next[ADDR_W-1:DATA_W];
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          if (field_done && state_q == GET_ADDR) begin
            addr_q <= field_next;
            if (cmd_q == CMD_EXEC) begin
              exec_addr_o <= field_next;
              state_q     <= EXEC_ACK;
            end else begin
              state_q <= GET_LEN;
            end
          end else if (field_done) begin
            len_q      <= field_next;
            ack_only_q <= 1'b0;
            state_q    <= SEND_ACK;
          end
        end
        SEND_ACK: begin
          if (!tx_busy_i) begin
            if (ack_only_q) state_q <= IDLE;
            else if (len_q == '0) state_q <= SEND_EOT;
            else if (cmd_q == CMD_WRITE) state_q <= WR_DATA;
            else state_q <= RD_FETCH;
          end
        end
        WR_DATA: begin
          if (rx_valid_i) begin
            addr_q <= addr_q + 64'd1;
            len_q  <= len_q - 64'd1;
            if (last_byte) state_q <= SEND_EOT;
          end
        end
        // Address is stable here, so read data is valid in RD_SEND
        RD_FETCH: state_q <= RD_SEND;
        RD_SEND: begin
          if (!tx_busy_i) begin
            addr_q  <= addr_q + 64'd1;
            len_q   <= len_q - 64'd1;
            state_q <= last_byte ? SEND_EOT : RD_FETCH;
          end
        end
        SEND_EOT, EXEC_ACK: begin
          if (!tx_busy_i) state_q <= IDLE;
        end
        EOC_CODE: begin
          if (!tx_busy_i) state_q <= EOC_EXIT;
        end
        EOC_EXIT: begin
          if (!tx_busy_i) begin
            exit_q     <= {{DATA_W{1'b0}}, exit_q[EXIT_W-1:DATA_W]};
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == CNT_W'(EXIT_BYTES - 1)) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst_i)
    state_q inside {IDLE, GET_ADDR, GET_LEN, SEND_ACK, WR_DATA, RD_FETCH,
                    RD_SEND, SEND_EOT, EXEC_ACK, EOC_CODE, EOC_EXIT})
    else $error("controller state out of range");

endmodule

// File: logic/uart_dbg_top.sv
// UART debug loader top level
// Receiver, transmitter, command controller and byte memory

`timescale 1ns/1ps

module uart_dbg_top import uart_dbg_pkg::*; #(
  parameter int CLKS_PER_BIT = 16,
  parameter int PARITY_EN    = 1,
  parameter int MEM_AW       = 10
) (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  input  logic              eoc_i,
  input  logic [EXIT_W-1:0] exit_code_i,
  output logic              exec_o,
  output logic [ADDR_W-1:0] exec_addr_o
);

  logic              rx_valid;
  byte_t             rx_data;
  logic              tx_start;
  byte_t             tx_data;
  logic              tx_busy;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_addr;
  byte_t             mem_wdata;
  byte_t             mem_rdata;

  ////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_uart_rx (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_uart_tx (
    .clk        (clk),
    .rst_i      (rst_i),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_data),
    .tx_busy_o  (tx_busy),
    .tx_o       (uart_tx_o)
  );

  ////////////////////////////////////////
  // Controller and memory
  ////////////////////////////////////////

  dbg_cmd_ctrl #(
    .MEM_AW (MEM_AW)
  ) u_dbg_cmd_ctrl (
    .clk         (clk),
    .rst_i       (rst_i),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .tx_busy_i   (tx_busy),
    .tx_start_o  (tx_start),
    .tx_data_o   (tx_data),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .eoc_i       (eoc_i),
    .exit_code_i (exit_code_i),
    .exec_o      (exec_o),
    .exec_addr_o (exec_addr_o)
  );

  dbg_byte_mem #(
    .MEM_AW (MEM_AW)
  ) u_dbg_byte_mem (
    .clk     (clk),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// File: tb/tb_uart_dbg_tasks.svh
// UART debug loader testbench tasks
// Host serial driver, reply monitor and the directed tests

`ifndef TB_UART_DBG_TASKS_SVH
`define TB_UART_DBG_TASKS_SVH

////////////////////////////////////////
// Serial line
////////////////////////////////////////

// Always 11 bit times, an extra idle bit when parity is off
task automatic send_byte(input byte_t data, input bit bad_parity = 1'b0);
  logic [10:0] frame;
  logic        par;
  int          i;
  par   = (PARITY_EN != 0) ? ((^data) ^ bad_parity) : 1'b1;
  frame = {1'b1, par, data, 1'b0};
  for (i = 0; i < 11; i++) begin
    @(posedge clk);
    uart_rx_i <= frame[i];
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  end
endtask

task automatic send_field(input logic [ADDR_W-1:0] value);
  int i;
  for (i = 0; i < FIELD_BYTES; i++) begin
    send_byte(value[8*i +: 8]);
  end
endtask

task automatic send_request(input byte_t cmd, input logic [ADDR_W-1:0] addr,
                            input logic [ADDR_W-1:0] len);
  send_byte(cmd);
  send_field(addr);
  send_field(len);
endtask

// Waits for a start bit, then samples each bit in its middle
task automatic recv_byte(output byte_t data);
  logic par;
  int   i;
  @(negedge clk);
  while (uart_tx_o !== 1'b0) @(negedge clk);
  repeat (CLKS_PER_BIT / 2) @(negedge clk);
  for (i = 0; i < DATA_W; i++) begin
    repeat (CLKS_PER_BIT) @(negedge clk);
    data[i] = uart_tx_o;
  end
  if (PARITY_EN != 0) begin
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = uart_tx_o;
    assert (par === ^data) else begin
      $display("error %0t: reply byte 0x%02h has parity bit %b", $time, data, par);
      errors++;
    end
  end
  repeat (CLKS_PER_BIT) @(negedge clk);
  assert (uart_tx_o === 1'b1) else begin
    $display("error %0t: reply byte 0x%02h has a low stop bit", $time, data);
    errors++;
  end
endtask

////////////////////////////////////////
// Checks
////////////////////////////////////////

task automatic expect_byte(input byte_t exp, input string what);
  int    waited;
  byte_t got;
  waited = 0;
  while (reply_q.size() == 0 && waited < REPLY_WAIT) begin
    @(negedge clk);
    waited++;
  end
  assert (reply_q.size() != 0) else begin
    $display("no reply byte arrived for %s within %0d cycles", what, REPLY_WAIT);
    errors++;
  end
  if (reply_q.size() != 0) begin
    got = reply_q.pop_front();
    assert (got == exp) else begin
      $display("error %0t: %s expected 0x%02h got 0x%02h", $time, what, exp, got);
      errors++;
    end
  end
endtask

// Three frame times with nothing on the reply line
task automatic expect_silence(input string what);
  repeat (3 * FRAME_CYCLES) @(negedge clk);
  assert (reply_q.size() == 0) else begin
    $display("DUT answered %s with %0d unexpected bytes", what, reply_q.size());
    errors++;
  end
  reply_q.delete();
endtask

task automatic finish_test(input string name, input int err_at_start);
  if (errors == err_at_start) begin
    pass_tests++;
    $display("test %s: pass", name);
  end else begin
    fail_tests++;
    $display("test %s: fail, %0d errors", name, errors - err_at_start);
  end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_ack_challenge();
  int e0;
  e0 = errors;
  send_byte(8'h55);
  expect_silence("stray byte 0x55");
  send_byte(CODE_ACK);
  expect_byte(CODE_ACK, "ACK challenge");
  finish_test("ack_challenge", e0);
endtask

task automatic test_write_read();
  byte_t data [20];
  int    e0;
  int    i;
  e0 = errors;
  for (i = 0; i < 20; i++) begin
    data[i] = byte_t'($random(seed));
  end
  send_request(CMD_WRITE, 64'h100, 64'd20);
  expect_byte(CODE_ACK, "write ACK");
  for (i = 0; i < 20; i++) begin
    send_byte(data[i]);
  end
  expect_byte(CODE_EOT, "write EOT");
  send_request(CMD_READ, 64'h100, 64'd20);
  expect_byte(CODE_ACK, "read ACK");
  for (i = 0; i < 20; i++) begin
    expect_byte(data[i], $sformatf("read byte %0d", i));
  end
  expect_byte(CODE_EOT, "read EOT");
  finish_test("write_read", e0);
endtask

// Six bytes from 0x3FE land at 0x3FE, 0x3FF and then 0 to 3
task automatic test_wrap_and_empty();
  byte_t data [6];
  int    e0;
  int    i;
  e0 = errors;
  for (i = 0; i < 6; i++) begin
    data[i] = byte_t'($random(seed));
  end
  send_request(CMD_WRITE, 64'h3fe, 64'd6);
  expect_byte(CODE_ACK, "wrap write ACK");
  for (i = 0; i < 6; i++) begin
    send_byte(data[i]);
  end
  expect_byte(CODE_EOT, "wrap write EOT");
  send_request(CMD_READ, 64'h0, 64'd4);
  expect_byte(CODE_ACK, "wrap read ACK");
  for (i = 0; i < 4; i++) begin
    expect_byte(data[i+2], $sformatf("wrapped byte %0d", i));
  end
  expect_byte(CODE_EOT, "wrap read EOT");
  send_request(CMD_READ, 64'h0, 64'd0);
  expect_byte(CODE_ACK, "empty read ACK");
  expect_byte(CODE_EOT, "empty read EOT");
  finish_test("wrap_and_empty", e0);
endtask

task automatic test_exec();
  logic [ADDR_W-1:0] entry;
  int                pulses0;
  int                e0;
  e0      = errors;
  entry   = {$random(seed), $random(seed)};
  pulses0 = exec_pulses;
  send_byte(CMD_EXEC);
  send_field(entry);
  expect_byte(CODE_ACK, "exec ACK");
  assert (exec_pulses == pulses0 + 1) else begin
    $display("error %0t: exec_o pulsed %0d times", $time, exec_pulses - pulses0);
    errors++;
  end
  assert (exec_addr_o == entry) else begin
    $display("error %0t: exec_addr_o 0x%016h, entry 0x%016h", $time, exec_addr_o, entry);
    errors++;
  end
  finish_test("exec", e0);
endtask

task automatic test_eoc();
  logic [EXIT_W-1:0] code;
  int                e0;
  int                i;
  e0   = errors;
  code = $random(seed);
  @(posedge clk);
  eoc_i       <= 1'b1;
  exit_code_i <= code;
  @(posedge clk);
  eoc_i <= 1'b0;
  expect_byte(CODE_EOC, "EOC code");
  for (i = 0; i < EXIT_BYTES; i++) begin
    expect_byte(code[8*i +: 8], $sformatf("exit code byte %0d", i));
  end
  finish_test("eoc", e0);
endtask

task automatic test_bad_parity();
  int e0;
  e0 = errors;
  send_byte(CODE_ACK, 1'b1);
  expect_silence("an ACK with bad parity");
  send_byte(CODE_ACK);
  expect_byte(CODE_ACK, "ACK after parity error");
  finish_test("bad_parity", e0);
endtask

`endif

// File: tb/tb_uart_dbg.sv
// UART debug loader testbench
// Drives the host side of the serial protocol and checks every reply byte

`timescale 1ns/1ps

module tb_uart_dbg import uart_dbg_pkg::*;;

  localparam int CLKS_PER_BIT = 16;
  localparam int PARITY_EN    = 1;
  localparam int MEM_AW       = 10;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int FRAME_CYCLES = 11 * CLKS_PER_BIT;
  localparam int REPLY_WAIT   = 4 * FRAME_CYCLES;
  // Frames sent and received over all tests, silence windows included
  localparam int TOTAL_FRAMES = 172;
  localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * 11 * CLKS_PER_BIT
                                   * CLK_PERIOD * 2;

  logic              clk = 1'b0;
  logic              rst_i;
  logic              uart_rx_i;
  logic              uart_tx_o;
  logic              eoc_i;
  logic [EXIT_W-1:0] exit_code_i;
  logic              exec_o;
  logic [ADDR_W-1:0] exec_addr_o;

  integer seed = 32'hcb3bfb83;
  int     errors = 0;
  int     pass_tests = 0;
  int     fail_tests = 0;
  int     exec_pulses = 0;
  byte_t  reply_q [$];
  byte_t  mon_byte;

  `include "tb_uart_dbg_tasks.svh"

  uart_dbg_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN),
    .MEM_AW       (MEM_AW)
  ) UUT (
    .clk         (clk),
    .rst_i       (rst_i),
    .uart_rx_i   (uart_rx_i),
    .uart_tx_o   (uart_tx_o),
    .eoc_i       (eoc_i),
    .exit_code_i (exit_code_i),
    .exec_o      (exec_o),
    .exec_addr_o (exec_addr_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Every byte the DUT transmits lands in the reply queue
  initial begin
    forever begin
      recv_byte(mon_byte);
      reply_q.push_back(mon_byte);
    end
  end

  always @(negedge clk) begin
    if (exec_o === 1'b1) begin
      exec_pulses++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_i       <= 1'b1;
    uart_rx_i   <= 1'b1;
    eoc_i       <= 1'b0;
    exit_code_i <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk);

    test_ack_challenge();
    test_write_read();
    test_wrap_and_empty();
    test_exec();
    test_eoc();
    test_bad_parity();

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_tests, fail_tests, errors);
    if (fail_tests == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+tb
common/uart_dbg_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/dbg_byte_mem.sv
logic/dbg_cmd_ctrl.sv
logic/uart_dbg_top.sv
tb/tb_uart_dbg.sv

// File: Makefile
# Verilator build and run for the UART debug loader

VERILATOR  ?= verilator
TOP        := tb_uart_dbg
RTL_TOP    := uart_dbg_top
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
